// ==== src/cnn_axi_bridge_pkg.sv ====
package cnn_axi_bridge_pkg;

    //////////////////////////////
    // Client counts
    //////////////////////////////
    localparam int NUM_RD_CLIENTS = 2;     // Read lanes
    localparam int NUM_WR_CLIENTS = 2;     // Write lanes

    //////////////////////////////
    // AXI field widths
    //////////////////////////////
    localparam int AXI_ID_WTH     = 4;
    localparam int AXI_ADDR_WTH   = 32;    // Byte address
    localparam int AXI_LEN_WTH    = 8;     // Beats minus one
    localparam int AXI_DATA_WTH   = 64;
    localparam int AXI_SIZE_WTH   = 3;
    localparam int AXI_BURST_WTH  = 2;
    localparam int AXI_WSTRB_WTH  = AXI_DATA_WTH / 8;  // One strobe per byte

    // Every lane moves full 8-byte beats
    localparam int AXI_SIZE_8B    = 3;     // 2**3 bytes per beat
    localparam int AXI_BURST_INCR = 1;     // Incrementing address

    //////////////////////////////
    // Field types
    //////////////////////////////
    typedef logic [AXI_ID_WTH-1:0]    axi_id_t;
    typedef logic [AXI_ADDR_WTH-1:0]  axi_addr_t;
    typedef logic [AXI_LEN_WTH-1:0]   axi_len_t;
    typedef logic [AXI_DATA_WTH-1:0]  axi_data_t;
    typedef logic [AXI_WSTRB_WTH-1:0] axi_strb_t;
    typedef logic [AXI_SIZE_WTH-1:0]  axi_size_t;
    typedef logic [AXI_BURST_WTH-1:0] axi_burst_t;

    // Burst request from an accelerator client
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;                    // Beats minus one
    } client_req_t;

    // One AR or AW beat
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    // One W beat
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    // Write lane FSM
    typedef enum logic [1:0] {
        WR_IDLE,                           // Waiting for an address handshake
        WR_DATA,                           // Streaming beats
        WR_RESP                            // Waiting on B channel
    } wr_state_t;

endpackage

// ==== src/cnn_axi_rd_bridge.sv ====
module cnn_axi_rd_bridge (
    input  logic                                   clk,
    input  logic                                   rst,
    // Client request side
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_req,
    input  cnn_axi_bridge_pkg::client_req_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0]
                                                   rd_req_info,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_req_ack,
    // Client data side
    output cnn_axi_bridge_pkg::axi_data_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0]
                                                   rd_data,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_data_vld,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_data_rdy,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_cmpl,
    // One AR channel per lane
    output cnn_axi_bridge_pkg::axi_ax_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0]
                                                   ar,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] arvalid,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] arready,
    // R channels sharing one ID
    input  cnn_axi_bridge_pkg::axi_data_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0]
                                                   rdata,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rvalid,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rlast,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rready,
    input  cnn_axi_bridge_pkg::axi_id_t            rid
);

    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] ar_hs;      // AR handshake per lane
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] r_hs;       // R beat accepted
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] last_hit;   // Last beat for this lane
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] cmpl_q;     // Registered completion

    //////////////////////////////
    // Per-lane forwarding
    //////////////////////////////
    for (genvar g = 0; g < cnn_axi_bridge_pkg::NUM_RD_CLIENTS; g++) begin : g_lane

        // Request held by the client until acked, so valid is just the level
        assign arvalid[g]    = rd_req[g];
        assign ar_hs[g]      = arvalid[g] & arready[g];
        assign rd_req_ack[g] = ar_hs[g];                // Zero-latency ack

        // Address beat fields
        assign ar[g].id    = rd_req_info[g].id;
        assign ar[g].addr  = rd_req_info[g].addr;
        assign ar[g].len   = rd_req_info[g].len;
        assign ar[g].size  = cnn_axi_bridge_pkg::axi_size_t'(cnn_axi_bridge_pkg::AXI_SIZE_8B);
        assign ar[g].burst =
            cnn_axi_bridge_pkg::axi_burst_t'(cnn_axi_bridge_pkg::AXI_BURST_INCR);

        // Data path straight through
        assign rd_data[g]     = rdata[g];
        assign rd_data_vld[g] = rvalid[g];
        assign rready[g]      = rd_data_rdy[g];

        // Beat only counts when the client took it
        assign r_hs[g] = rvalid[g] & rready[g];

        // Shared RID names the lane index
        assign last_hit[g] = r_hs[g] & rlast[g] &
                             (rid == cnn_axi_bridge_pkg::axi_id_t'(g));

    end

    //////////////////////////////
    // Completion pulse
    //////////////////////////////
    // One-cycle pulse after the accepted last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            cmpl_q <= '0;
        end else begin
            cmpl_q <= last_hit;    // Falls again unless another last beat lands
        end
    end

    assign rd_cmpl = cmpl_q;

endmodule

// ==== src/cnn_axi_wr_channel.sv ====
module cnn_axi_wr_channel (
    input  logic                            clk,
    input  logic                            rst,
    // Client request side
    input  logic                            wr_req,
    input  cnn_axi_bridge_pkg::client_req_t wr_req_info,
    output logic                            wr_req_ack,
    // Client data side
    input  cnn_axi_bridge_pkg::axi_data_t   wr_data,
    input  logic                            wr_data_vld,
    output logic                            wr_data_rdy,
    output logic                            wr_cmpl,
    // AW channel
    output cnn_axi_bridge_pkg::axi_ax_t     aw,
    output logic                            awvalid,
    input  logic                            awready,
    // W channel
    output cnn_axi_bridge_pkg::axi_w_t      w,
    output logic                            wvalid,
    input  logic                            wready,
    // B channel
    input  logic                            bvalid,
    output logic                            bready
);

    cnn_axi_bridge_pkg::wr_state_t state_q;    // Lane FSM
    cnn_axi_bridge_pkg::wr_state_t state_d;
    cnn_axi_bridge_pkg::axi_len_t  len_q;      // Captured burst length
    cnn_axi_bridge_pkg::axi_len_t  beat_cnt_q; // Beats accepted so far

    logic aw_hs;       // Address handshake
    logic w_hs;        // Data beat accepted
    logic cnt_at_len;  // Count reached the length
    logic wlast;

    //////////////////////////////
    // AW forwarding
    //////////////////////////////
    assign awvalid    = wr_req;                 // Client holds until ack
    assign aw_hs      = awvalid & awready;
    assign wr_req_ack = aw_hs;

    assign aw.id    = wr_req_info.id;
    assign aw.addr  = wr_req_info.addr;
    assign aw.len   = wr_req_info.len;
    assign aw.size  = cnn_axi_bridge_pkg::axi_size_t'(cnn_axi_bridge_pkg::AXI_SIZE_8B);
    assign aw.burst = cnn_axi_bridge_pkg::axi_burst_t'(cnn_axi_bridge_pkg::AXI_BURST_INCR);

    //////////////////////////////
    // W pass-through
    //////////////////////////////
    assign wvalid      = wr_data_vld;
    assign wr_data_rdy = wready;
    assign w_hs        = wvalid & wready;

    assign w.data = wr_data;
    assign w.strb = '1;                         // Full beats only
    assign w.last = wlast;

    // Last flag while the beat on the bus is number len+1
    assign cnt_at_len = (beat_cnt_q == len_q);
    assign wlast      = (state_q == cnn_axi_bridge_pkg::WR_DATA) & cnt_at_len;

    //////////////////////////////
    // B channel
    //////////////////////////////
    assign bready  = 1'b1;                      // Response always taken
    assign wr_cmpl = bvalid;

    //////////////////////////////
    // Lane FSM
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            cnn_axi_bridge_pkg::WR_IDLE: begin
                if (aw_hs) begin
                    state_d = cnn_axi_bridge_pkg::WR_DATA;
                end
            end
            cnn_axi_bridge_pkg::WR_DATA: begin
                // Leave after the last beat is accepted
                if (w_hs && cnt_at_len) begin
                    state_d = cnn_axi_bridge_pkg::WR_RESP;
                end
            end
            cnn_axi_bridge_pkg::WR_RESP: begin
                if (bvalid) begin
                    state_d = cnn_axi_bridge_pkg::WR_IDLE;
                end
            end
            default: begin
                state_d = cnn_axi_bridge_pkg::WR_IDLE;  // Unused encoding
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= cnn_axi_bridge_pkg::WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Beat counter restarts from zero on every new burst
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q <= '0;
        end else if (state_q == cnn_axi_bridge_pkg::WR_IDLE && aw_hs) begin
            beat_cnt_q <= '0;
        end else if (state_q == cnn_axi_bridge_pkg::WR_DATA && w_hs) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;    // Holds while wready low
        end
    end

    // Burst length taken on the address handshake
    always_ff @(posedge clk) begin
        if (state_q == cnn_axi_bridge_pkg::WR_IDLE && aw_hs) begin
            len_q <= wr_req_info.len;
        end
    end

endmodule

// ==== src/cnn_layer_accel_axi_bridge.sv ====
module cnn_layer_accel_axi_bridge (
    input  logic clk,
    input  logic rst,

    //////////////////////////////
    // Read clients
    //////////////////////////////
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_req,
    input  cnn_axi_bridge_pkg::client_req_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0]
                 rd_req_info,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_req_ack,
    output cnn_axi_bridge_pkg::axi_data_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0]
                 rd_data,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_data_vld,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_data_rdy,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_cmpl,

    //////////////////////////////
    // Write clients
    //////////////////////////////
    input  logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_req,
    input  cnn_axi_bridge_pkg::client_req_t [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0]
                 wr_req_info,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_req_ack,
    input  cnn_axi_bridge_pkg::axi_data_t [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0]
                 wr_data,
    input  logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_data_vld,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_data_rdy,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_cmpl,

    //////////////////////////////
    // AXI read masters
    //////////////////////////////
    output cnn_axi_bridge_pkg::axi_id_t    [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arid,
    output cnn_axi_bridge_pkg::axi_addr_t  [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_araddr,
    output cnn_axi_bridge_pkg::axi_len_t   [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arlen,
    output cnn_axi_bridge_pkg::axi_size_t  [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arsize,
    output cnn_axi_bridge_pkg::axi_burst_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arburst,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arvalid,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arready,
    input  cnn_axi_bridge_pkg::axi_id_t                   axi_rid,     // Shared by all lanes
    input  cnn_axi_bridge_pkg::axi_data_t  [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_rdata,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_rlast,
    input  logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_rvalid,
    output logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_rready,

    //////////////////////////////
    // AXI write masters
    //////////////////////////////
    output cnn_axi_bridge_pkg::axi_id_t    [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awid,
    output cnn_axi_bridge_pkg::axi_addr_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awaddr,
    output cnn_axi_bridge_pkg::axi_len_t   [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awlen,
    output cnn_axi_bridge_pkg::axi_size_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awsize,
    output cnn_axi_bridge_pkg::axi_burst_t [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awburst,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awvalid,
    input  logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awready,
    output cnn_axi_bridge_pkg::axi_data_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wdata,
    output cnn_axi_bridge_pkg::axi_strb_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wstrb,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wlast,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wvalid,
    input  logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wready,
    input  logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_bvalid,
    output logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_bready
);

    // Lane structs between the bridges and the flat AXI ports
    cnn_axi_bridge_pkg::axi_ax_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] ar;
    cnn_axi_bridge_pkg::axi_ax_t [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] aw;
    cnn_axi_bridge_pkg::axi_w_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] w;

    //////////////////////////////
    // Read side
    //////////////////////////////
    cnn_axi_rd_bridge u_rd_bridge (
        .clk         (clk),
        .rst         (rst),
        .rd_req      (rd_req),
        .rd_req_info (rd_req_info),
        .rd_req_ack  (rd_req_ack),
        .rd_data     (rd_data),
        .rd_data_vld (rd_data_vld),
        .rd_data_rdy (rd_data_rdy),
        .rd_cmpl     (rd_cmpl),
        .ar          (ar),
        .arvalid     (axi_arvalid),
        .arready     (axi_arready),
        .rdata       (axi_rdata),
        .rvalid      (axi_rvalid),
        .rlast       (axi_rlast),
        .rready      (axi_rready),
        .rid         (axi_rid)
    );

    // Split AR beats onto the port fields
    for (genvar g = 0; g < cnn_axi_bridge_pkg::NUM_RD_CLIENTS; g++) begin : g_rd
        assign axi_arid[g]    = ar[g].id;
        assign axi_araddr[g]  = ar[g].addr;
        assign axi_arlen[g]   = ar[g].len;
        assign axi_arsize[g]  = ar[g].size;
        assign axi_arburst[g] = ar[g].burst;
    end

    //////////////////////////////
    // Write side
    //////////////////////////////
    for (genvar g = 0; g < cnn_axi_bridge_pkg::NUM_WR_CLIENTS; g++) begin : g_wr
        cnn_axi_wr_channel u_wr_channel (
            .clk         (clk),
            .rst         (rst),
            .wr_req      (wr_req[g]),
            .wr_req_info (wr_req_info[g]),
            .wr_req_ack  (wr_req_ack[g]),
            .wr_data     (wr_data[g]),
            .wr_data_vld (wr_data_vld[g]),
            .wr_data_rdy (wr_data_rdy[g]),
            .wr_cmpl     (wr_cmpl[g]),
            .aw          (aw[g]),
            .awvalid     (axi_awvalid[g]),
            .awready     (axi_awready[g]),
            .w           (w[g]),
            .wvalid      (axi_wvalid[g]),
            .wready      (axi_wready[g]),
            .bvalid      (axi_bvalid[g]),
            .bready      (axi_bready[g])
        );

        // AW fields
        assign axi_awid[g]    = aw[g].id;
        assign axi_awaddr[g]  = aw[g].addr;
        assign axi_awlen[g]   = aw[g].len;
        assign axi_awsize[g]  = aw[g].size;
        assign axi_awburst[g] = aw[g].burst;

        // W fields
        assign axi_wdata[g] = w[g].data;
        assign axi_wstrb[g] = w[g].strb;
        assign axi_wlast[g] = w[g].last;    // From the lane beat counter
    end

endmodule

// ==== tb/tb_cnn_axi_bridge.sv ====
module tb_cnn_axi_bridge;

    //////////////////////////////
    // Clock, reset, bookkeeping
    //////////////////////////////
    logic clk = 1'b0;
    logic rst;
    int   seed         = 48;           // $random state
    int   mismatch_cnt = 0;
    int   other_cnt    = 0;
    int   cycle_cnt    = 0;

    // Read clients
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_req, rd_req_ack, rd_data_vld;
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_data_rdy, rd_cmpl;
    cnn_axi_bridge_pkg::client_req_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_req_info;
    cnn_axi_bridge_pkg::axi_data_t   [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_data;
    // Write clients
    logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_req, wr_req_ack, wr_data_vld;
    logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_data_rdy, wr_cmpl;
    cnn_axi_bridge_pkg::client_req_t [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_req_info;
    cnn_axi_bridge_pkg::axi_data_t   [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] wr_data;
    // AXI read masters
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arvalid, axi_arready, axi_rvalid;
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_rlast, axi_rready;
    cnn_axi_bridge_pkg::axi_id_t    [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arid;
    cnn_axi_bridge_pkg::axi_addr_t  [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_araddr;
    cnn_axi_bridge_pkg::axi_len_t   [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arlen;
    cnn_axi_bridge_pkg::axi_size_t  [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arsize;
    cnn_axi_bridge_pkg::axi_burst_t [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_arburst;
    cnn_axi_bridge_pkg::axi_data_t  [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] axi_rdata;
    cnn_axi_bridge_pkg::axi_id_t                                             axi_rid;
    // AXI write masters
    logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awvalid, axi_awready, axi_wvalid;
    logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wready, axi_wlast, axi_bvalid, axi_bready;
    cnn_axi_bridge_pkg::axi_id_t    [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awid;
    cnn_axi_bridge_pkg::axi_addr_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awaddr;
    cnn_axi_bridge_pkg::axi_len_t   [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awlen;
    cnn_axi_bridge_pkg::axi_size_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awsize;
    cnn_axi_bridge_pkg::axi_burst_t [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_awburst;
    cnn_axi_bridge_pkg::axi_data_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wdata;
    cnn_axi_bridge_pkg::axi_strb_t  [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] axi_wstrb;

    // Handshakes seen at the falling edge, applied at the next rising edge
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] rd_hit_l;
    logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] aw_hs_l, w_hs_l, b_l, w_last_hs_l;
    cnn_axi_bridge_pkg::axi_len_t len_l [cnn_axi_bridge_pkg::NUM_WR_CLIENTS];
    // Expected lane state
    logic [cnn_axi_bridge_pkg::NUM_RD_CLIENTS-1:0] exp_cmpl;
    logic [cnn_axi_bridge_pkg::NUM_WR_CLIENTS-1:0] in_data, in_resp, exp_wlast, b_pend;
    cnn_axi_bridge_pkg::axi_len_t exp_cnt [cnn_axi_bridge_pkg::NUM_WR_CLIENTS];
    cnn_axi_bridge_pkg::axi_len_t exp_len [cnn_axi_bridge_pkg::NUM_WR_CLIENTS];

    cnn_layer_accel_axi_bridge DUT (.*);

    always #10 clk = ~clk;

    function automatic logic coin_flip();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [31:0] random_word();
        random_word = $random(seed);
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_cnt++;
        $display("mismatch at time %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    //////////////////////////////
    // Client stimulus
    //////////////////////////////
    task automatic read_lane_requests(input int lane);
        logic [31:0] r;
        repeat (6) begin
            r = random_word();
            @(posedge clk);
            #1;
            rd_req[lane]           = 1'b1;
            rd_req_info[lane].id   = cnn_axi_bridge_pkg::axi_id_t'(lane);
            rd_req_info[lane].addr = {r[31:3], 3'b000};          // 8-byte aligned
            rd_req_info[lane].len  = {4'h0, r[3:0]};
            do begin
                @(negedge clk);
            end while (!rd_req_ack[lane]);                       // Held through arready stalls
            @(posedge clk);
            #1;
            rd_req[lane] = 1'b0;
        end
    endtask

    // Address, len+1 beats with gaps, then wait for the response
    task automatic write_lane_bursts(input int lane);
        logic [31:0] r;
        int          beats;
        int          sent;
        repeat (4) begin
            r = random_word();
            @(posedge clk);
            #1;
            wr_req[lane]           = 1'b1;
            wr_req_info[lane].id   = cnn_axi_bridge_pkg::axi_id_t'(lane + 4);
            wr_req_info[lane].addr = {r[31:3], 3'b000};
            wr_req_info[lane].len  = {4'h0, r[3:0]};            // 0 to 15
            do begin
                @(negedge clk);
            end while (!wr_req_ack[lane]);
            @(posedge clk);
            #1;
            wr_req[lane] = 1'b0;
            beats        = int'(r[3:0]) + 1;
            sent         = 0;
            while (sent < beats) begin
                wr_data_vld[lane] = coin_flip() | coin_flip();   // Mostly valid
                wr_data[lane]     = {random_word(), random_word()};
                @(negedge clk);
                if (wr_data_vld[lane] && axi_wready[lane]) begin
                    sent++;
                end
                @(posedge clk);
                #1;
            end
            wr_data_vld[lane] = 1'b0;
            do begin
                @(negedge clk);
            end while (!wr_cmpl[lane]);
        end
    endtask

    initial begin
        rst         = 1'b1;
        rd_req      = '0;
        rd_req_info = '0;
        wr_req      = '0;
        wr_req_info = '0;
        wr_data     = '0;
        wr_data_vld = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            read_lane_requests(0);
            read_lane_requests(1);
            write_lane_bursts(0);
            write_lane_bursts(1);
        join
        repeat (4) @(posedge clk);
        finish_run();
    end

    //////////////////////////////
    // AXI slave and read back-pressure
    //////////////////////////////
    // Runs through reset too, so random R traffic meets the reset check
    initial begin
        logic [31:0] r;
        axi_arready = '0;
        axi_rvalid  = '0;
        axi_rlast   = '0;
        axi_rdata   = '0;
        axi_rid     = '0;
        rd_data_rdy = '0;
        axi_awready = '0;
        axi_wready  = '0;
        axi_bvalid  = '0;
        b_pend      = '0;
        w_last_hs_l = '0;
        forever begin
            @(posedge clk);
            #1;
            r       = random_word();
            axi_rid = {2'b00, r[1:0]};                           // 2 and 3 name no lane
            for (int i = 0; i < cnn_axi_bridge_pkg::NUM_RD_CLIENTS; i++) begin
                axi_arready[i] = coin_flip();
                axi_rvalid[i]  = coin_flip();
                axi_rlast[i]   = coin_flip();
                axi_rdata[i]   = {random_word(), random_word()};
                rd_data_rdy[i] = coin_flip();
            end
            for (int i = 0; i < cnn_axi_bridge_pkg::NUM_WR_CLIENTS; i++) begin
                axi_awready[i] = coin_flip();
                axi_wready[i]  = coin_flip();
                b_pend[i]      = b_pend[i] | w_last_hs_l[i];      // Response owed
                axi_bvalid[i]  = b_pend[i] & coin_flip();
                if (axi_bvalid[i]) begin
                    b_pend[i] = 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // Expected values
    //////////////////////////////
    always @(negedge clk) begin
        for (int i = 0; i < cnn_axi_bridge_pkg::NUM_RD_CLIENTS; i++) begin
            rd_hit_l[i] = axi_rvalid[i] & rd_data_rdy[i] & axi_rlast[i] &
                          (axi_rid == cnn_axi_bridge_pkg::axi_id_t'(i));
        end
        for (int i = 0; i < cnn_axi_bridge_pkg::NUM_WR_CLIENTS; i++) begin
            aw_hs_l[i]     = wr_req[i] & axi_awready[i];
            w_hs_l[i]      = wr_data_vld[i] & axi_wready[i];
            b_l[i]         = axi_bvalid[i];
            len_l[i]       = wr_req_info[i].len;
            w_last_hs_l[i] = axi_wvalid[i] & axi_wready[i] & axi_wlast[i];
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_cmpl <= '0;
            in_data  <= '0;
            in_resp  <= '0;
            for (int i = 0; i < cnn_axi_bridge_pkg::NUM_WR_CLIENTS; i++) begin
                exp_cnt[i] <= '0;
                exp_len[i] <= '0;
            end
        end else begin
            exp_cmpl <= rd_hit_l;                                // One cycle late
            for (int i = 0; i < cnn_axi_bridge_pkg::NUM_WR_CLIENTS; i++) begin
                if (in_data[i]) begin
                    if (w_hs_l[i] && exp_cnt[i] == exp_len[i]) begin
                        in_data[i] <= 1'b0;
                        in_resp[i] <= 1'b1;
                    end else if (w_hs_l[i]) begin
                        exp_cnt[i] <= exp_cnt[i] + 8'd1;
                    end
                end else if (in_resp[i]) begin
                    in_resp[i] <= ~b_l[i];
                end else if (aw_hs_l[i]) begin
                    in_data[i] <= 1'b1;
                    exp_cnt[i] <= '0;                            // Fresh count per burst
                    exp_len[i] <= len_l[i];
                end
            end
        end
    end

    // 8 bursts of up to 16 beats at about 4 cycles each, plus margin
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == 2000) begin
            other_cnt++;
            $display("Timeout: the tests did not finish within 2000 cycles");
            finish_run();
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    rst_quiet: assert property (@(negedge clk) rst |-> (rd_cmpl == '0 && axi_wlast == '0))
        else report_mismatch("rd_cmpl or wlast high in reset");

    for (genvar g = 0; g < cnn_axi_bridge_pkg::NUM_RD_CLIENTS; g++) begin : g_rd_chk
        ar_valid: assert property (@(negedge clk) disable iff (rst)
            axi_arvalid[g] == rd_req[g] &&
            rd_req_ack[g] == (axi_arvalid[g] && axi_arready[g]))
            else report_mismatch($sformatf("read lane %0d arvalid or ack", g));
        ar_hold: assert property (@(negedge clk) disable iff (rst)
            $past(axi_arvalid[g] && !axi_arready[g]) |-> axi_arvalid[g])
            else report_mismatch($sformatf("read lane %0d dropped a stalled request", g));
        ar_fields: assert property (@(negedge clk) disable iff (rst)
            axi_arid[g] == rd_req_info[g].id && axi_araddr[g] == rd_req_info[g].addr &&
            axi_arlen[g] == rd_req_info[g].len && axi_arsize[g] == 3'd3 &&
            axi_arburst[g] == 2'd1)
            else report_mismatch($sformatf("read lane %0d AR fields", g));
        r_pass: assert property (@(negedge clk) disable iff (rst)
            rd_data[g] == axi_rdata[g] && rd_data_vld[g] == axi_rvalid[g] &&
            axi_rready[g] == rd_data_rdy[g])
            else report_mismatch($sformatf("read lane %0d data pass-through", g));
        r_cmpl: assert property (@(negedge clk) disable iff (rst) rd_cmpl[g] == exp_cmpl[g])
            else report_mismatch($sformatf("read lane %0d rd_cmpl", g));
    end

    for (genvar g = 0; g < cnn_axi_bridge_pkg::NUM_WR_CLIENTS; g++) begin : g_wr_chk
        assign exp_wlast[g] = in_data[g] && (exp_cnt[g] == exp_len[g]);

        aw_valid: assert property (@(negedge clk) disable iff (rst)
            axi_awvalid[g] == wr_req[g] &&
            wr_req_ack[g] == (axi_awvalid[g] && axi_awready[g]))
            else report_mismatch($sformatf("write lane %0d awvalid or ack", g));
        aw_fields: assert property (@(negedge clk) disable iff (rst)
            axi_awid[g] == wr_req_info[g].id && axi_awaddr[g] == wr_req_info[g].addr &&
            axi_awlen[g] == wr_req_info[g].len && axi_awsize[g] == 3'd3 &&
            axi_awburst[g] == 2'd1)
            else report_mismatch($sformatf("write lane %0d AW fields", g));
        w_pass: assert property (@(negedge clk) disable iff (rst)
            axi_wvalid[g] == wr_data_vld[g] && axi_wdata[g] == wr_data[g] &&
            wr_data_rdy[g] == axi_wready[g] && axi_wstrb[g] == 8'hFF && axi_bready[g])
            else report_mismatch($sformatf("write lane %0d W pass-through", g));
        w_last: assert property (@(negedge clk) disable iff (rst) axi_wlast[g] == exp_wlast[g])
            else report_mismatch($sformatf("write lane %0d wlast", g));
        b_cmpl: assert property (@(negedge clk) disable iff (rst) wr_cmpl[g] == axi_bvalid[g])
            else report_mismatch($sformatf("write lane %0d wr_cmpl", g));
    end

endmodule

// ==== cnn_axi_bridge.f ====
src/cnn_axi_bridge_pkg.sv
src/cnn_axi_rd_bridge.sv
src/cnn_axi_wr_channel.sv
src/cnn_layer_accel_axi_bridge.sv
tb/tb_cnn_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cnn_axi_bridge \
    -f cnn_axi_bridge.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
